// File: include/vtl_settings.svh
// raster geometry, i/o port numbers, memory map and fixed colour indices of the video chip
// included by any block that needs one of these numbers
`ifndef VTL_SETTINGS_SVH
`define VTL_SETTINGS_SVH

// horizontal, in F14M clocks
`define H_SYNC        66   // hsync low time
`define H_BACK        78   // back porch after hsync
`define LEFT_BORDER   72
`define ACTIVE_WIDTH  640  // one pixel per clock in gr 5
`define H_VISIBLE     798  // border + active + border
`define H_FRONT       10
`define LINE_LEN      (`H_SYNC + `H_BACK + `H_VISIBLE + `H_FRONT)  // 952

// vertical, in lines
`define V_SYNC        4
`define V_BLANK       2    // blanked lines at top of frame
`define TOP_BORDER    64
`define ACTIVE_HEIGHT 192
`define V_TOTAL       312

`define HCNT_RESET    7    // first hsync fall 945 clocks after reset

// z80 i/o ports
`define PORT_BANK0    8'h40  // 40h..43h bank registers
`define PORT_VIDEO    8'h44
`define PORT_COLORS   8'h45

// memory map
`define MAPPED_IO_BANK 4'd2
`define MAPPED_IO_LO   14'h2800
`define MAPPED_IO_HI   14'h2FFF
`define RAM_BANK_LO    4'd4
`define RAM_BANK_HI    4'd7

`define FORCED_BLANK_COLOR 4'hC
`define BLANK_COLOR        4'h0

`endif

// File: verilog/vtl_pkg.sv
// shared types of the video chip and the interfaces that carry them between its blocks
// compile this file before any module of the design
package vtl_pkg;

	typedef logic [7:0]  byte_t;        // cpu data, sdram data, video bytes
	typedef logic [15:0] cpu_addr_t;
	typedef logic [3:0]  bank_t;        // 16k bank number
	typedef logic [13:0] vram_addr_t;   // offset inside one 16k page
	typedef logic [24:0] sdram_addr_t;
	typedef logic [9:0]  raster_cnt_t;  // hcnt, vcnt, ycnt
	typedef logic [3:0]  color_idx_t;   // palette index
	typedef logic [5:0]  channel_t;     // one colour gun

	// cpu slot inside every 4 clocks, equal to hcnt[1:0]
	typedef enum logic [1:0] {
		phase_execute = 2'd0,  // z80 steps
		phase_access  = 2'd1,  // sdram address / write
		phase_sample  = 2'd2,  // DI loaded, write ends
		phase_idle    = 2'd3   // every other one is a video fetch
	} cpu_phase_t;

endpackage

interface raster_if import vtl_pkg::*; ();
	raster_cnt_t hcnt;
	raster_cnt_t ycnt;        // row inside active area
	logic        in_active;
	logic        in_border;
	logic        in_blank;
	logic [2:0]  byte_phase;  // column within the current video byte
	logic        row_start;   // load row address on this fetch slot
	modport source (output hcnt, ycnt, in_active, in_border, in_blank, byte_phase, row_start);
	modport sink   (input hcnt, ycnt, in_active, in_border, in_blank, byte_phase, row_start);
endinterface

interface video_regs_if import vtl_pkg::*; ();
	color_idx_t border_color;
	color_idx_t fg_color;
	color_idx_t bg_color;
	logic       page_7;          // video ram in page 7, else page 3
	logic       graphic_enable;
	modport source (output border_color, fg_color, bg_color, page_7, graphic_enable);
	modport sink   (input border_color, fg_color, bg_color, page_7, graphic_enable);
endinterface

interface port_write_if import vtl_pkg::*; ();
	logic  io_wr_stb;      // one clock, sample phase
	logic  mem_io_wr_stb;  // one clock, access phase
	byte_t port;
	byte_t wdata;
	modport source (output io_wr_stb, mem_io_wr_stb, port, wdata);
	modport sink   (input io_wr_stb, mem_io_wr_stb, port, wdata);
endinterface

// File: verilog/video_timing.sv
// raster counters, negative syncs and region flags for the 952 x 312 frame
// one instance feeds the fetcher and the cpu slot phase
`include "vtl_settings.svh"

module video_timing import vtl_pkg::*; (
	input  logic F14M,
	input  logic RESET,
	raster_if.source raster,
	output logic hsync,
	output logic vsync
);
	localparam raster_cnt_t vis_start = raster_cnt_t'(`H_SYNC + `H_BACK);
	localparam raster_cnt_t vis_end   = raster_cnt_t'(`H_SYNC + `H_BACK + `H_VISIBLE);
	localparam raster_cnt_t act_start = raster_cnt_t'(`H_SYNC + `H_BACK + `LEFT_BORDER);
	localparam raster_cnt_t act_end   = raster_cnt_t'(`H_SYNC + `H_BACK + `LEFT_BORDER + `ACTIVE_WIDTH);
	localparam raster_cnt_t row_load  = raster_cnt_t'(`H_SYNC + `H_BACK + `LEFT_BORDER - 17);
	localparam raster_cnt_t line_last = raster_cnt_t'(`LINE_LEN - 1);
	localparam raster_cnt_t top_end   = raster_cnt_t'(`TOP_BORDER);
	localparam raster_cnt_t bot_start = raster_cnt_t'(`TOP_BORDER + `ACTIVE_HEIGHT);

	raster_cnt_t hcnt;
	raster_cnt_t vcnt;
	raster_cnt_t ycnt;
	logic        line_end;

	assign line_end = hcnt == line_last;

	always_ff @(posedge F14M) begin
		if (RESET) begin
			hcnt <= raster_cnt_t'(`HCNT_RESET);
			vcnt <= '0;
			ycnt <= '0;
		end else if (line_end) begin
			hcnt <= '0;
			vcnt <= (vcnt == raster_cnt_t'(`V_TOTAL - 1)) ? '0 : vcnt + 10'd1;
			// restart on last top border line, so first active line is row 0
			ycnt <= (vcnt == top_end - 10'd1) ? '0 : ycnt + 10'd1;
		end else begin
			hcnt <= hcnt + 10'd1;
		end
	end

	assign hsync = !(hcnt < raster_cnt_t'(`H_SYNC));  // low at start of line
	assign vsync = !(vcnt < raster_cnt_t'(`V_SYNC));

	assign raster.hcnt       = hcnt;
	assign raster.ycnt       = ycnt;
	assign raster.in_blank   = hcnt < vis_start || hcnt >= vis_end ||
	                           vcnt < raster_cnt_t'(`V_BLANK);
	assign raster.in_active  = hcnt >= act_start && hcnt < act_end &&
	                           vcnt >= top_end && vcnt < bot_start;
	assign raster.in_border  = !raster.in_blank && !raster.in_active;
	assign raster.byte_phase = 3'(hcnt - act_start);
	assign raster.row_start  = hcnt == row_load;  // two bytes ahead of the first pixel

	// wrap must happen at line_last, the fetch and cpu slots rely on it
	a_hcnt_wrap: assert property (@(posedge F14M) disable iff (RESET)
		hcnt < raster_cnt_t'(`LINE_LEN));

endmodule

// File: verilog/cpu_bus_cycle.sv
// z80 side of the chip with clock enable, sdram slot sharing, bank mapping and DI capture
// drives the sdram port for both the cpu and the video fetch
`include "vtl_settings.svh"

module cpu_bus_cycle import vtl_pkg::*; (
	input  logic        F14M,
	input  logic        RESET,
	input  logic        MREQ_n,
	input  logic        IORQ_n,
	input  logic        RD_n,
	input  logic        WR_n,
	input  cpu_addr_t   A,
	input  byte_t       DO,
	input  logic [6:0]  KD,
	input  logic        CASIN,
	input  byte_t       sdram_dout,
	input  bank_t [3:0] banks,       // from the port registers
	input  vram_addr_t  video_addr,  // next byte the fetcher wants
	input  logic        page_7,
	input  cpu_phase_t  hcnt_phase,
	output logic        CPUENA,
	output byte_t       DI,
	output sdram_addr_t sdram_addr,
	output byte_t       sdram_din,
	output logic        sdram_rd,
	output logic        sdram_wr,
	port_write_if.source pw
);
	logic       mreq;
	logic       iorq;
	logic       rd;
	logic       wr;
	bank_t      bank;
	vram_addr_t offset;
	logic       bank_is_ram;
	logic       mapped_io;
	logic       video_turn;  // every second idle phase is hcnt mod 8 == 7

	assign mreq = ~MREQ_n;
	assign iorq = ~IORQ_n;
	assign rd   = ~RD_n;
	assign wr   = ~WR_n;

	assign bank        = banks[A[15:14]];
	assign offset      = A[13:0];
	assign bank_is_ram = bank >= `RAM_BANK_LO && bank <= `RAM_BANK_HI;
	assign mapped_io   = bank == `MAPPED_IO_BANK &&
	                     offset >= `MAPPED_IO_LO && offset <= `MAPPED_IO_HI;

	assign pw.io_wr_stb     = iorq && wr && hcnt_phase == phase_sample;
	assign pw.mem_io_wr_stb = mreq && wr && mapped_io && hcnt_phase == phase_access;
	assign pw.port          = A[7:0];
	assign pw.wdata         = DO;

	always_ff @(posedge F14M) begin
		if (RESET) begin
			CPUENA     <= 1'b0;
			sdram_rd   <= 1'b0;
			sdram_wr   <= 1'b0;
			DI         <= '0;
			video_turn <= 1'b1;  // hcnt resets to 7 so the first idle is a video slot
		end else begin
			CPUENA <= hcnt_phase == phase_idle;  // high through the execute phase
			case (hcnt_phase)
				phase_access: begin
					sdram_addr <= {7'd0, bank, offset};
					sdram_rd   <= mreq && rd;
					if (mreq && wr && !mapped_io) begin
						sdram_wr  <= bank_is_ram;  // rom banks ignore writes
						sdram_din <= DO;
					end
				end
				phase_sample: begin
					sdram_rd <= 1'b0;
					sdram_wr <= 1'b0;
					if (mreq && rd)
						DI <= mapped_io ? {CASIN, KD} : sdram_dout;
				end
				phase_idle: begin
					if (video_turn) begin
						sdram_addr <= {7'd0, page_7 ? 4'd7 : 4'd3, video_addr};
						sdram_rd   <= 1'b1;
					end
					video_turn <= ~video_turn;
				end
				default: ;  // execute phase leaves the bus quiet
			endcase
		end
	end

	// write pulse covers only the sample phase and never a video read
	a_wr_slot: assert property (@(posedge F14M) disable iff (RESET)
		sdram_wr |-> hcnt_phase == phase_sample);

	// DI is captured on the clock right after the cpu address went out
	a_sample_after_access: assert property (@(posedge F14M) disable iff (RESET)
		hcnt_phase == phase_access |=> hcnt_phase == phase_sample);

endmodule

// File: verilog/port_registers.sv
// bank table, video registers and the memory mapped latch
// written from the z80 through the bus cycle strobes
`include "vtl_settings.svh"

module port_registers import vtl_pkg::*; (
	input  logic        F14M,
	input  logic        RESET,
	port_write_if.sink  pw,
	output bank_t [3:0] banks,   // one per 16k cpu window
	video_regs_if.source vr,
	output logic        BUZZER,
	output logic        CASOUT
);
	byte_t      bank_off;
	logic [1:0] bank_sel;
	logic       bank_port;

	assign bank_off  = pw.port - `PORT_BANK0;
	assign bank_sel  = bank_off[1:0];
	assign bank_port = bank_off < 8'd4;  // 40h..43h, lower ports wrap high

	always_ff @(posedge F14M) begin
		if (RESET) begin
			banks             <= '0;
			vr.border_color   <= '0;
			vr.fg_color       <= '0;
			vr.bg_color       <= '0;
			vr.page_7         <= 1'b0;
			vr.graphic_enable <= 1'b0;
			BUZZER            <= 1'b0;
			CASOUT            <= 1'b0;
		end else begin
			if (pw.io_wr_stb) begin
				if (bank_port) begin
					banks[bank_sel] <= pw.wdata[3:0];
				end else if (pw.port == `PORT_VIDEO) begin
					vr.border_color <= pw.wdata[7:4];
					vr.page_7       <= ~pw.wdata[3];  // bit 3 low selects page 7
				end else if (pw.port == `PORT_COLORS) begin
					vr.fg_color <= pw.wdata[7:4];
					vr.bg_color <= pw.wdata[3:0];
				end
			end
			// mapped latch in bank 2, 2800h..2fffh
			if (pw.mem_io_wr_stb) begin
				vr.graphic_enable <= pw.wdata[3];
				CASOUT            <= pw.wdata[2];
				BUZZER            <= pw.wdata[0];
			end
		end
	end

endmodule

// File: verilog/gr5_fetch_shifter.sv
// gr 5 pixel path: row address, video byte fetch, shifter and colour index select
// pixel is registered once per clock and goes straight to the palette
`include "vtl_settings.svh"

module gr5_fetch_shifter import vtl_pkg::*; (
	input  logic       F14M,
	input  logic       RESET,
	raster_if.sink     raster,
	video_regs_if.sink vr,
	input  byte_t      sdram_dout,
	input  logic       blank,
	output vram_addr_t video_addr,
	output color_idx_t pixel
);
	raster_cnt_t y;
	vram_addr_t  row_base;
	byte_t       fetched;   // byte read in the last video slot
	byte_t       shifter;   // lsb is the current pixel

	assign y = raster.ycnt;

	// 80 bytes a row, rows interleaved in 8 x 8 x 3 groups
	assign row_base = {y[2], y[1], y[0], y[5], y[4], y[3], y[7], y[6], y[7], y[6], 4'b0000};

	always_ff @(posedge F14M) begin
		if (RESET)
			video_addr <= '0;
		else if (raster.row_start)
			video_addr <= row_base;
		else if (raster.byte_phase == 3'd7)
			video_addr <= video_addr + 14'd1;  // fetch slot took the old value
	end

	always_ff @(posedge F14M) begin
		if (raster.byte_phase == 3'd0)
			fetched <= sdram_dout;  // one clock after the video address went out
		if (raster.byte_phase == 3'd7)
			shifter <= fetched;
		else if (raster.in_active)
			shifter <= shifter >> 1;
	end

	always_ff @(posedge F14M) begin
		if (RESET)
			pixel <= `BLANK_COLOR;
		else if (raster.in_blank)
			pixel <= `BLANK_COLOR;
		else if (blank)
			pixel <= `FORCED_BLANK_COLOR;
		else if (raster.in_border)
			pixel <= vr.border_color;
		else if (vr.graphic_enable && shifter[0])
			pixel <= vr.fg_color;
		else
			pixel <= vr.bg_color;  // also whole area when graphics off
	end

endmodule

// File: verilog/palette.sv
// 16 entry colour table, 4 bits per gun widened to the 6 bit outputs
// pure lookup on the registered pixel index
module palette import vtl_pkg::*; (
	input  color_idx_t pixel,
	output channel_t   r,
	output channel_t   g,
	output channel_t   b
);
	logic [11:0] rgb;  // 4:4:4

	always_comb begin
		case (pixel)
			4'h0:    rgb = 12'h000;  // black
			4'h1:    rgb = 12'h00f;  // blue
			4'h2:    rgb = 12'h0a0;  // green
			4'h3:    rgb = 12'h08a;  // cyan
			4'h4:    rgb = 12'hf00;  // red
			4'h5:    rgb = 12'h808;  // magenta
			4'h6:    rgb = 12'h790;  // yellow
			4'h7:    rgb = 12'h888;  // light grey
			4'h8:    rgb = 12'h666;  // dark grey
			4'h9:    rgb = 12'h66f;
			4'ha:    rgb = 12'h6f6;
			4'hb:    rgb = 12'h6ff;
			4'hc:    rgb = 12'hf66;  // forced blank colour
			4'hd:    rgb = 12'hf6f;
			4'he:    rgb = 12'hff6;
			default: rgb = 12'hfff;  // white
		endcase
	end

	// two zero lsbs on each gun
	assign r = {rgb[11:8], 2'b00};
	assign g = {rgb[7:4], 2'b00};
	assign b = {rgb[3:0], 2'b00};

endmodule

// File: verilog/vtl_chip.sv
// laser 500 video and bus chip, gr 5 only, between z80, sdram and crt
// instantiate once, clocked by F14M, cpu stepped with CPUENA
module vtl_chip import vtl_pkg::*; (
	input  logic        F14M,        // pixel clock
	input  logic        RESET,
	input  logic        MREQ_n,
	input  logic        IORQ_n,
	input  logic        RD_n,
	input  logic        WR_n,
	input  cpu_addr_t   A,
	input  byte_t       DO,          // z80 data out
	input  logic [6:0]  KD,          // keyboard lines
	input  logic        CASIN,
	input  byte_t       sdram_dout,
	input  logic        blank,       // forced blank while downloading
	output logic        CPUENA,
	output byte_t       DI,          // z80 data in
	output sdram_addr_t sdram_addr,
	output byte_t       sdram_din,
	output logic        sdram_rd,
	output logic        sdram_wr,
	output logic        hsync,
	output logic        vsync,
	output channel_t    r,
	output channel_t    g,
	output channel_t    b,
	output logic        BUZZER,
	output logic        CASOUT
);
	bank_t [3:0] banks;
	vram_addr_t  video_addr;
	color_idx_t  pixel;  // registered colour index

	raster_if     raster ();
	video_regs_if vr ();
	port_write_if pw ();

	video_timing timing_i (
		.F14M   (F14M),
		.RESET  (RESET),
		.raster (raster.source),
		.hsync  (hsync),
		.vsync  (vsync)
	);

	cpu_bus_cycle bus_i (
		.F14M       (F14M),
		.RESET      (RESET),
		.MREQ_n     (MREQ_n),
		.IORQ_n     (IORQ_n),
		.RD_n       (RD_n),
		.WR_n       (WR_n),
		.A          (A),
		.DO         (DO),
		.KD         (KD),
		.CASIN      (CASIN),
		.sdram_dout (sdram_dout),
		.banks      (banks),
		.video_addr (video_addr),
		.page_7     (vr.page_7),
		.hcnt_phase (cpu_phase_t'(raster.hcnt[1:0])),  // slot follows the pixel counter
		.CPUENA     (CPUENA),
		.DI         (DI),
		.sdram_addr (sdram_addr),
		.sdram_din  (sdram_din),
		.sdram_rd   (sdram_rd),
		.sdram_wr   (sdram_wr),
		.pw         (pw.source)
	);

	port_registers regs_i (
		.F14M   (F14M),
		.RESET  (RESET),
		.pw     (pw.sink),
		.banks  (banks),
		.vr     (vr.source),
		.BUZZER (BUZZER),
		.CASOUT (CASOUT)
	);

	gr5_fetch_shifter fetch_i (
		.F14M       (F14M),
		.RESET      (RESET),
		.raster     (raster.sink),
		.vr         (vr.sink),
		.sdram_dout (sdram_dout),
		.blank      (blank),
		.video_addr (video_addr),
		.pixel      (pixel)
	);

	palette palette_i (.pixel(pixel), .r(r), .g(g), .b(b));

endmodule

// File: verification/vtl_chip_tb.sv
// testbench for the gr 5 video chip with an sdram model, a raster model and a table of z80 cycles
// top module vtl_chip_tb is built from filelist.f together with the design
`include "vtl_settings.svh"

module vtl_chip_tb import vtl_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	typedef enum logic [2:0] {
		op_io_wr,     // z80 out to a port
		op_mem_wr,    // write with the model byte checked after
		op_latch_wr,  // mapped latch write with {CASOUT, BUZZER} checked
		op_mem_rd,    // read with DI checked
		op_fill,      // whole 16k page of the model set to one byte
		op_screen     // wait for {line, clock} and check rgb
	} op_t;

	typedef struct packed {
		op_t         op;
		logic [19:0] addr;      // cpu address, page number, or {line, clock}
		byte_t       data;
		byte_t       expected;
	} row_t;

	localparam int frame_clks    = `LINE_LEN * `V_TOTAL;
	localparam int timeout_clks  = 3 * frame_clks;  // up to three screen waits of a frame each
	localparam int first_hs_fall = 945;             // hcnt starts at 7
	localparam logic [11:0] palette_table [16] = '{
		12'h000, 12'h00f, 12'h0a0, 12'h08a, 12'hf00, 12'h808, 12'h790, 12'h888,
		12'h666, 12'h66f, 12'h6f6, 12'h6ff, 12'hf66, 12'hf6f, 12'hff6, 12'hfff
	};

	logic F14M = 1'b0;
	logic RESET, MREQ_n, IORQ_n, RD_n, WR_n, CASIN, blank;
	cpu_addr_t A;
	byte_t DO, DI, sdram_dout, sdram_din;
	logic [6:0] KD;
	logic CPUENA, sdram_rd, sdram_wr, hsync, vsync, BUZZER, CASOUT;
	sdram_addr_t sdram_addr;
	channel_t r, g, b;

	byte_t mem [0:131071];  // banks 0..7 of 16k
	logic  fill_go = 1'b0;
	logic [2:0] fill_page = '0;
	byte_t fill_val = '0;
	int    cycles = 0;      // clocks since reset release
	logic  live = 1'b0;
	bank_t bank_shadow [4] = '{default: '0};
	row_t  rows [$];
	logic  hs_prev = 1'b0, vs_prev = 1'b0;  // both low in reset
	logic  first_hs_seen = 1'b0, vs_fall_seen = 1'b0, vs_checked = 1'b0;
	int    hs_low = 0, vs_low = 0;

	vtl_chip dut_i (
		.F14M(F14M), .RESET(RESET), .MREQ_n(MREQ_n), .IORQ_n(IORQ_n), .RD_n(RD_n),
		.WR_n(WR_n), .A(A), .DO(DO), .KD(KD), .CASIN(CASIN), .sdram_dout(sdram_dout),
		.blank(blank), .CPUENA(CPUENA), .DI(DI), .sdram_addr(sdram_addr),
		.sdram_din(sdram_din), .sdram_rd(sdram_rd), .sdram_wr(sdram_wr), .hsync(hsync),
		.vsync(vsync), .r(r), .g(g), .b(b), .BUZZER(BUZZER), .CASOUT(CASOUT)
	);

	always #4 F14M = ~F14M;  // 8 ns

	// power-up contents depend on every address bit
	function automatic byte_t fill_byte(input logic [16:0] addr);
		return addr[7:0] ^ addr[15:8] ^ {7'd0, addr[16]};
	endfunction

	function automatic logic [17:0] palette_rgb(input color_idx_t idx);
		logic [11:0] c;
		c = palette_table[idx];
		return {c[11:8], 2'b00, c[7:4], 2'b00, c[3:0], 2'b00};
	endfunction

	function automatic int raster_h();
		return (`HCNT_RESET + cycles) % `LINE_LEN;
	endfunction

	function automatic int raster_v();
		return ((`HCNT_RESET + cycles) / `LINE_LEN) % `V_TOTAL;
	endfunction

	assign sdram_dout = mem[sdram_addr[16:0]];  // combinational read

	always @(posedge F14M) begin
		if (RESET) begin
			for (int i = 0; i < 131072; i++)
				mem[17'(i)] <= fill_byte(17'(i));
		end else begin
			if (sdram_wr)
				mem[sdram_addr[16:0]] <= sdram_din;
			if (fill_go)
				for (int i = 0; i < 16384; i++)
					mem[{fill_page, 14'(i)}] <= fill_val;
		end
	end

	task automatic stop_on_error(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		$display("** FAIL **");
		$fatal(1);
	endtask

	// clock count and run limit
	always @(posedge F14M) begin
		live <= !RESET;
		if (RESET) begin
			cycles <= 0;
		end else if (cycles >= timeout_clks) begin
			$display("simulation timed out after %0d clocks, a wait never ended", cycles);
			$display("** FAIL **");
			$fatal(1);
		end else begin
			cycles <= cycles + 1;
		end
	end

	// syncs, CPUENA and sdram_rd checked against the raster model every clock
	always @(negedge F14M) begin
		int h;
		int v;
		if (live) begin
			h = raster_h();
			v = raster_v();
			assert (hsync == (h >= `H_SYNC))
				else stop_on_error($sformatf("hsync %0b at hcnt %0d", hsync, h));
			assert (vsync == (v >= `V_SYNC))
				else stop_on_error($sformatf("vsync %0b at vcnt %0d", vsync, v));
			assert (CPUENA == (h % 4 == 0))
				else stop_on_error($sformatf("CPUENA %0b at hcnt %0d", CPUENA, h));
			// video slot at hcnt mod 8 == 7 reads on the next clock
			if (h % 8 == 0)
				assert (sdram_rd)
					else stop_on_error($sformatf("no sdram read after video slot, hcnt %0d", h));
			if (h % 4 == 2)  // cpu read follows the access phase
				assert (sdram_rd == (!MREQ_n && !RD_n))
					else stop_on_error($sformatf("sdram_rd %0b in cpu sample clock, hcnt %0d",
						sdram_rd, h));
			if (hs_prev && !hsync && !first_hs_seen) begin
				assert (cycles == first_hs_fall)
					else stop_on_error($sformatf("first hsync fall after %0d clocks", cycles));
				first_hs_seen = 1'b1;
			end
			if (!hsync)
				hs_low = hs_prev ? 1 : hs_low + 1;
			else if (!hs_prev && first_hs_seen)
				assert (hs_low == `H_SYNC)
					else stop_on_error($sformatf("hsync low for %0d clocks", hs_low));
			if (vs_prev && !vsync)
				vs_fall_seen = 1'b1;
			if (!vsync) begin
				vs_low = vs_prev ? 1 : vs_low + 1;
			end else if (!vs_prev && vs_fall_seen) begin
				assert (vs_low == `V_SYNC * `LINE_LEN)
					else stop_on_error($sformatf("vsync low for %0d clocks", vs_low));
				vs_checked = 1'b1;
			end
			hs_prev = hsync;
			vs_prev = vsync;
		end
	end

	// one z80 cycle held 4 clocks from the execute phase
	task automatic run_bus_cycle(input op_t op, input cpu_addr_t addr, input byte_t data);
		do @(negedge F14M); while (!CPUENA);
		A  = addr;
		DO = data;
		case (op)
			op_io_wr: begin
				IORQ_n = 1'b0;
				WR_n   = 1'b0;
			end
			op_mem_wr: begin
				MREQ_n = 1'b0;
				WR_n   = 1'b0;
			end
			default: begin  // read
				MREQ_n = 1'b0;
				RD_n   = 1'b0;
			end
		endcase
		repeat (4) @(negedge F14M);
		MREQ_n = 1'b1;
		IORQ_n = 1'b1;
		RD_n   = 1'b1;
		WR_n   = 1'b1;
	endtask

	task automatic wait_raster_pos(input int line, input int clk);
		do @(negedge F14M); while (!(live && raster_h() == clk && raster_v() == line));
	endtask

	task automatic apply_row(input row_t row);
		logic [16:0] model_addr;
		model_addr = {bank_shadow[row.addr[15:14]][2:0], row.addr[13:0]};  // only banks 0..7 used
		case (row.op)
			op_io_wr: begin
				run_bus_cycle(op_io_wr, row.addr[15:0], row.data);
				if (row.addr[7:0] >= `PORT_BANK0 && row.addr[7:0] < `PORT_BANK0 + 8'd4)
					bank_shadow[row.addr[1:0]] = row.data[3:0];
			end
			op_mem_wr: begin
				run_bus_cycle(op_mem_wr, row.addr[15:0], row.data);
				assert (mem[model_addr] == row.expected)
					else stop_on_error($sformatf("sdram %h holds %h, expected %h",
						model_addr, mem[model_addr], row.expected));
			end
			op_latch_wr: begin
				run_bus_cycle(op_mem_wr, row.addr[15:0], row.data);
				assert ({CASOUT, BUZZER} == row.expected[1:0])
					else stop_on_error($sformatf("CASOUT/BUZZER %b%b, expected %b",
						CASOUT, BUZZER, row.expected[1:0]));
			end
			op_mem_rd: begin
				run_bus_cycle(op_mem_rd, row.addr[15:0], row.data);
				assert (DI == row.expected)
					else stop_on_error($sformatf("DI %h at %h, expected %h",
						DI, row.addr[15:0], row.expected));
			end
			op_fill: begin
				@(negedge F14M);
				fill_page = row.addr[2:0];
				fill_val  = row.data;
				fill_go   = 1'b1;
				@(negedge F14M);
				fill_go   = 1'b0;
			end
			default: begin  // screen
				wait_raster_pos(int'(row.addr[19:10]), int'(row.addr[9:0]));
				assert ({r, g, b} == palette_rgb(row.expected[3:0]))
					else stop_on_error($sformatf("rgb %h at line %0d clock %0d, colour %h",
						{r, g, b}, row.addr[19:10], row.addr[9:0], row.expected[3:0]));
			end
		endcase
	endtask

	task automatic add_row(input op_t op, input logic [19:0] addr, input byte_t data,
		input byte_t expected);
		rows.push_back({op, addr, data, expected});
	endtask

	initial begin
		RESET  = 1'b1;
		MREQ_n = 1'b1;
		IORQ_n = 1'b1;
		RD_n   = 1'b1;
		WR_n   = 1'b1;
		A      = '0;
		DO     = '0;
		KD     = 7'h35;
		CASIN  = 1'b1;  // latch read gives b5h
		blank  = 1'b0;

		add_row(op_io_wr, 20'h00040, 8'h00, 8'h00);     // banks 0, 2, 4, 5
		add_row(op_io_wr, 20'h00041, 8'h02, 8'h00);
		add_row(op_io_wr, 20'h00042, 8'h04, 8'h00);
		add_row(op_io_wr, 20'h00043, 8'h05, 8'h00);
		add_row(op_mem_wr, 20'h0c123, 8'h5a, 8'h5a);    // ram bank 5
		add_row(op_mem_wr, 20'h00200, 8'h77, 8'h02);    // rom bank 0 keeps its power-up byte
		add_row(op_mem_rd, 20'h0c123, 8'h00, 8'h5a);
		add_row(op_mem_rd, 20'h00123, 8'h00, 8'h22);    // untouched power-up byte
		add_row(op_latch_wr, 20'h06800, 8'h05, 8'h03);  // CASOUT and BUZZER on
		add_row(op_mem_rd, 20'h06900, 8'h00, 8'hb5);    // {CASIN, KD}
		add_row(op_io_wr, 20'h00044, 8'h50, 8'h00);     // border 5 and bit 3 low selects page 7
		add_row(op_screen, {10'd30, 10'd400}, 8'h00, 8'h05);
		add_row(op_io_wr, 20'h00045, 8'ha3, 8'h00);     // fg a, bg 3
		add_row(op_latch_wr, 20'h06800, 8'h08, 8'h00);  // graphics on with CASOUT and BUZZER off
		add_row(op_fill, 20'h00007, 8'hff, 8'h00);
		add_row(op_screen, {10'd100, 10'd500}, 8'h00, 8'h0a);
		add_row(op_fill, 20'h00007, 8'h00, 8'h00);
		add_row(op_screen, {10'd100, 10'd500}, 8'h00, 8'h03);

		repeat (3) @(posedge F14M);
		@(negedge F14M);
		RESET = 1'b0;

		foreach (rows[i])
			apply_row(rows[i]);

		assert (first_hs_seen && vs_checked)
			else stop_on_error("no complete hsync or vsync pulse was measured");
		$display("** PASS **");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+include
verilog/vtl_pkg.sv
verilog/video_timing.sv
verilog/cpu_bus_cycle.sv
verilog/port_registers.sv
verilog/gr5_fetch_shifter.sv
verilog/palette.sv
verilog/vtl_chip.sv
verification/vtl_chip_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the vtl_chip testbench with verilator, run it, and search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	-f filelist.f --top-module vtl_chip_tb --Mdir obj_dir -o vtl_chip_tb_sim \
	&& ./obj_dir/vtl_chip_tb_sim > sim.log 2>&1
grep -q '^\*\* PASS \*\*$' sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
